// ==== Makefile ====
TOP = tb_u2plus_core

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f u2plus_core.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== source/bus_control.sv ====
////////////////////////////////////////////////////////////
// Wishbone slave front end. Decodes the region, strobes the
// selected slave for one cycle, registers ack and read data,
// and runs the bootloader reset controller.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_control import core_pkg::*; (
   input  logic     wb_clk,
   input  logic     por_rst,
   input  wb_addr_t wb_adr_i,
   input  wb_data_t wb_dat_i,
   input  logic     wb_we_i,
   input  logic     wb_stb_i,
   input  logic     wb_cyc_i,
   output wb_data_t wb_dat_o,
   output logic     wb_ack_o,
   input  logic     bldr_done_i,
   output logic     core_rst_o,
   wb_slave_if.ctrl rb_bus,
   wb_slave_if.ctrl set_bus,
   wb_slave_if.ctrl pic_bus
);

   logic       accept;
   logic [7:0] top_byte;
   logic       hit_rb, hit_set, hit_pic;
   wb_data_t   rd_data;
   logic       bldr_state;

   ////////////////////////////////////////////////////////////
   // Address decode
   assign top_byte = wb_adr_i[AW-1 -: 8];
   assign hit_rb   = (top_byte & REGION_READBACK_MASK) == REGION_READBACK;
   assign hit_set  = (top_byte & REGION_SETTINGS_MASK) == REGION_SETTINGS;
   assign hit_pic  = (top_byte & REGION_PIC_MASK) == REGION_PIC;

   // Held strobe is taken once, ack blocks the retake
   assign accept = wb_stb_i & wb_cyc_i & ~wb_ack_o;

   assign rb_bus.sel   = accept & hit_rb;
   assign set_bus.sel  = accept & hit_set;
   assign pic_bus.sel  = accept & hit_pic;

   assign rb_bus.we    = wb_we_i;
   assign set_bus.we   = wb_we_i;
   assign pic_bus.we   = wb_we_i;
   assign rb_bus.adr   = wb_adr_i;
   assign set_bus.adr  = wb_adr_i;
   assign pic_bus.adr  = wb_adr_i;
   assign rb_bus.dat_w  = wb_dat_i;
   assign set_bus.dat_w = wb_dat_i;
   assign pic_bus.dat_w = wb_dat_i;

   always_comb begin
      if (hit_rb)       rd_data = rb_bus.dat_r;
      else if (hit_set) rd_data = set_bus.dat_r;
      else if (hit_pic) rd_data = pic_bus.dat_r;
      else              rd_data = '0;   // Unmapped reads as zero
   end

   always_ff @(posedge wb_clk) begin
      if (por_rst) wb_ack_o <= 1'b0;
      else         wb_ack_o <= accept;
   end

   always_ff @(posedge wb_clk) begin
      if (accept) wb_dat_o <= wb_we_i ? '0 : rd_data;
   end

   ////////////////////////////////////////////////////////////
   // Bootloader reset controller
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         bldr_state <= BLDR_WAIT;
         core_rst_o <= 1'b0;
      end else begin
         core_rst_o <= 1'b0;
         case (bldr_state)
            BLDR_WAIT: begin
               if (bldr_done_i) begin   // Set by the bootloader
                  bldr_state <= BLDR_DONE;
                  core_rst_o <= 1'b1;
               end
            end
            default: bldr_state <= BLDR_DONE;   // Stays here until power-on reset
         endcase
      end
   end

endmodule

// ==== source/core_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared constants and types for the control bus core.
// Import with a wildcard in the module header of any block
// that decodes regions, settings or readback words.
////////////////////////////////////////////////////////////

package core_pkg;

   // Bus widths
   localparam int DW = 32;
   localparam int AW = 16;

   typedef logic [DW-1:0] wb_data_t;
   typedef logic [AW-1:0] wb_addr_t;

   // Region codes, compared against the top address byte
   localparam logic [7:0] REGION_READBACK      = 8'b0101_1100;
   localparam logic [7:0] REGION_READBACK_MASK = 8'b1111_1100;
   localparam logic [7:0] REGION_SETTINGS      = 8'b0111_0000;
   localparam logic [7:0] REGION_SETTINGS_MASK = 8'b1111_0000;
   localparam logic [7:0] REGION_PIC           = 8'b1000_0000;
   localparam logic [7:0] REGION_PIC_MASK      = 8'b1111_1100;

   // Settings bus word address, from adr[9:2]
   typedef logic [7:0] set_addr_t;

   localparam set_addr_t SR_MISC  = 8'd0;    // 7 regs
   localparam set_addr_t SR_DIVSW = 8'd180;  // 2 regs

   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;
   localparam logic       DIVSW_RESET   = 1'b1;

   // Bump when the register map changes (major, minor)
   localparam wb_data_t COMPAT_NUM = {16'd8, 16'd2};

   // Readback word map
   localparam int         RB_WORDS  = 16;
   localparam logic [3:0] RB_ADC0   = 4'd6;
   localparam logic [3:0] RB_ADC1   = 4'd7;
   localparam logic [3:0] RB_COMPAT = 4'd12;
   localparam logic [3:0] RB_MISC   = 4'd13;

   // Interrupt controller registers, adr[4:2]
   localparam logic [2:0] PIC_MASK    = 3'd0;
   localparam logic [2:0] PIC_PENDING = 3'd1;
   localparam logic [2:0] PIC_RAW     = 3'd2;
   localparam int         IRQ_W       = 16;

   // Bootloader control states
   localparam logic BLDR_WAIT = 1'b0;
   localparam logic BLDR_DONE = 1'b1;

endpackage

// ==== source/pic.sv ====
////////////////////////////////////////////////////////////
// Interrupt controller. Captures rising irq edges into the
// pending register; int_o is any pending bit not masked.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pic import core_pkg::*; (
   input  logic             wb_clk,
   input  logic             por_rst,
   input  logic             core_rst_i,
   wb_slave_if.slave        bus,
   input  logic [IRQ_W-1:0] irq_i,
   output logic             int_o
);

   logic [IRQ_W-1:0] irq_q, irq_qq;
   logic [IRQ_W-1:0] mask, pending, rise, clr;
   logic [2:0]       reg_idx;

   assign reg_idx = bus.adr[4:2];
   assign rise    = irq_q & ~irq_qq;

   // Write 1 to clear
   assign clr = (bus.sel && bus.we && reg_idx == PIC_PENDING) ? bus.dat_w[IRQ_W-1:0] : '0;

   always_ff @(posedge wb_clk) begin
      if (por_rst | core_rst_i) begin
         irq_q   <= '0;
         irq_qq  <= '0;
         pending <= '0;
         mask    <= '1;   // All masked out of reset
      end else begin
         irq_q   <= irq_i;
         irq_qq  <= irq_q;
         pending <= (pending & ~clr) | rise;   // New edge wins over clear
         if (bus.sel && bus.we && reg_idx == PIC_MASK)
            mask <= bus.dat_w[IRQ_W-1:0];
      end
   end

   assign int_o = |(pending & ~mask);

   always_comb begin
      case (reg_idx)
         PIC_MASK:    bus.dat_r = {{(DW-IRQ_W){1'b0}}, mask};
         PIC_PENDING: bus.dat_r = {{(DW-IRQ_W){1'b0}}, pending};
         PIC_RAW:     bus.dat_r = {{(DW-IRQ_W){1'b0}}, irq_q};
         default:     bus.dat_r = '0;
      endcase
   end

endmodule

// ==== source/readback_mux.sv ====
////////////////////////////////////////////////////////////
// Status readback map. Selects one word by adr[5:2] for
// reads in the readback region.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module readback_mux import core_pkg::*; (
   wb_slave_if.slave  bus,
   input  logic [11:0] adc0_a_i,
   input  logic [11:0] adc0_b_i,
   input  logic [11:0] adc1_a_i,
   input  logic [11:0] adc1_b_i,
   input  logic [1:0]  aux_ld_i,
   input  logic        button_i,
   input  logic        clk_status_i
);

   logic [$clog2(RB_WORDS)-1:0] rb_idx;
   wb_data_t                    misc_word;

   assign rb_idx = bus.adr[5:2];

   // aux_ld2, aux_ld1, button, spare, clk_status in bits 15..11
   assign misc_word = {16'b0, aux_ld_i[1], aux_ld_i[0], button_i, 1'b0,
                       clk_status_i, 11'b0};

   always_comb begin
      case (rb_idx)
         RB_ADC0:   bus.dat_r = {adc0_a_i, 4'b0, adc0_b_i, 4'b0};
         RB_ADC1:   bus.dat_r = {adc1_a_i, 4'b0, adc1_b_i, 4'b0};
         RB_COMPAT: bus.dat_r = COMPAT_NUM;
         RB_MISC:   bus.dat_r = misc_word;
         default:   bus.dat_r = '0;   // Retired words
      endcase
   end

endmodule

// ==== source/settings_regs.sv ====
////////////////////////////////////////////////////////////
// Settings register file in the settings region. Holds the
// clock generator, PHY, boot, diversity and LED controls and
// mixes hardware run flags with the software LED value.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module settings_regs import core_pkg::*; (
   input  logic       wb_clk,
   input  logic       por_rst,
   input  logic       core_rst_i,
   wb_slave_if.slave  bus,
   input  logic [3:0] run_i,
   output logic       bldr_done_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       clock_ready_o,
   output logic [1:0] lms_res_o,
   output logic       phy_reset_n_o,
   output logic [1:0] div_sw_o,
   output logic [7:0] leds_o
);

   set_addr_t  set_addr;
   logic       set_stb;
   logic [6:0] clock_outs;
   logic [7:0] led_sw, led_src, led_hw;
   logic       phy_reset;

   assign set_addr = bus.adr[9:2];
   assign set_stb  = bus.sel & bus.we;

   always_ff @(posedge wb_clk) begin
      if (por_rst | core_rst_i) begin
         clock_outs  <= '0;
         led_sw      <= '0;
         phy_reset   <= 1'b0;
         bldr_done_o <= 1'b0;
         led_src     <= LED_SRC_RESET;
         div_sw_o    <= {DIVSW_RESET, DIVSW_RESET};
      end else if (set_stb) begin
         case (set_addr)
            SR_MISC + 8'd0:  clock_outs  <= bus.dat_w[6:0];
            SR_MISC + 8'd3:  led_sw      <= bus.dat_w[7:0];
            SR_MISC + 8'd4:  phy_reset   <= bus.dat_w[0];
            SR_MISC + 8'd5:  bldr_done_o <= bus.dat_w[0];
            SR_MISC + 8'd6:  led_src     <= bus.dat_w[7:0];
            SR_DIVSW + 8'd0: div_sw_o[0] <= bus.dat_w[0];
            SR_DIVSW + 8'd1: div_sw_o[1] <= bus.dat_w[0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign lms_res_o     = clock_outs[6:5];
   assign phy_reset_n_o = ~phy_reset;

   // LEDs, src bit 1 = hardware, 0 = software
   // run_i is {tx0, rx0, tx1, rx1}
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign bus.dat_r = '0;   // Write-only region

endmodule

// ==== source/u2plus_core.sv ====
////////////////////////////////////////////////////////////
// Control bus core top level. An external Wishbone master
// reaches the readback, settings and interrupt regions
// through plain ports, all on wb_clk.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module u2plus_core import core_pkg::*; (
   input  logic             wb_clk,
   input  logic             por_rst,
   // Wishbone slave
   input  wb_addr_t         wb_adr_i,
   input  wb_data_t         wb_dat_i,
   input  logic             wb_we_i,
   input  logic             wb_stb_i,
   input  logic             wb_cyc_i,
   output wb_data_t         wb_dat_o,
   output logic             wb_ack_o,
   // Settings outputs
   input  logic [3:0]       run_i,   // tx0, rx0, tx1, rx1
   output logic [1:0]       clk_en_o,
   output logic [1:0]       clk_sel_o,
   output logic             clock_ready_o,
   output logic [1:0]       lms_res_o,
   output logic             phy_reset_n_o,
   output logic [1:0]       div_sw_o,
   output logic [7:0]       leds_o,
   // Status inputs
   input  logic [11:0]      adc0_a_i,
   input  logic [11:0]      adc0_b_i,
   input  logic [11:0]      adc1_a_i,
   input  logic [11:0]      adc1_b_i,
   input  logic [1:0]       aux_ld_i,
   input  logic             button_i,
   input  logic             clk_status_i,
   // Interrupts
   input  logic [IRQ_W-1:0] irq_i,
   output logic             int_o
);

   logic bldr_done;
   logic core_rst;

   wb_slave_if #(.DW(DW), .AW(AW)) rb_bus  ();
   wb_slave_if #(.DW(DW), .AW(AW)) set_bus ();
   wb_slave_if #(.DW(DW), .AW(AW)) pic_bus ();

   bus_control i_bus_control (
      .wb_clk, .por_rst,
      .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_stb_i, .wb_cyc_i,
      .wb_dat_o, .wb_ack_o,
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst),
      .rb_bus, .set_bus, .pic_bus
   );

   settings_regs i_settings_regs (
      .wb_clk, .por_rst,
      .core_rst_i  (core_rst),
      .bus         (set_bus),
      .run_i,
      .bldr_done_o (bldr_done),
      .clk_en_o, .clk_sel_o, .clock_ready_o, .lms_res_o,
      .phy_reset_n_o, .div_sw_o, .leds_o
   );

   readback_mux i_readback_mux (
      .bus (rb_bus),
      .adc0_a_i, .adc0_b_i, .adc1_a_i, .adc1_b_i,
      .aux_ld_i, .button_i, .clk_status_i
   );

   pic i_pic (
      .wb_clk, .por_rst,
      .core_rst_i (core_rst),
      .bus        (pic_bus),
      .irq_i, .int_o
   );

endmodule

// ==== source/wb_slave_if.sv ====
////////////////////////////////////////////////////////////
// One decoded bus region between the bus control block and
// a slave. Select is a one-cycle access strobe; read data
// is combinational in the slave.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb_slave_if #(
   parameter int DW = 32,
   parameter int AW = 16
);
   logic          sel;    // Access accepted this cycle
   logic          we;
   logic [AW-1:0] adr;
   logic [DW-1:0] dat_w;
   logic [DW-1:0] dat_r;

   modport ctrl  (output sel, output we, output adr, output dat_w, input dat_r);
   modport slave (input sel, input we, input adr, input dat_w, output dat_r);

endinterface

// ==== tb/core_checker.sv ====
////////////////////////////////////////////////////////////
// Bus and output monitor for the control bus testbench.
// Checks ack timing and read data on its own, and compares
// the DUT outputs whenever the stimulus asks for it.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_checker import core_pkg::*; (
   input  logic        wb_clk,
   input  logic        por_rst,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   input  logic        wb_we_i,
   input  logic        wb_ack_i,
   input  wb_data_t    wb_dat_i,
   input  wb_data_t    exp_rd_i,    // Expected data of the current read
   input  logic        outs_chk_i,
   input  logic [18:0] outs_i,      // DUT outputs, packed by the testbench
   input  logic [18:0] exp_outs_i,
   input  logic        test_end_i,
   input  logic [3:0]  test_id_i,
   input  logic        report_i,
   output int          err_count_o
);

   logic     acc_q, rd_q;
   wb_data_t exp_q;
   int       errors = 0;
   int       checks = 0;
   int       tests = 0;
   int       errs_before = 0;

   assign err_count_o = errors;

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   always @(posedge wb_clk) begin
      if (por_rst) begin
         acc_q <= 1'b0;
         rd_q  <= 1'b0;
      end else begin
         compare("wb_ack_o", {31'b0, acc_q}, {31'b0, wb_ack_i});   // One cycle after accept
         if (acc_q && rd_q)
            compare("wb_dat_o", exp_q, wb_dat_i);
         acc_q <= wb_stb_i & wb_cyc_i & ~acc_q;
         if (wb_stb_i && wb_cyc_i && !acc_q) begin
            rd_q  <= ~wb_we_i;
            exp_q <= exp_rd_i;
         end
         if (outs_chk_i) begin
            compare("lms_res_o", 32'(exp_outs_i[18:17]), 32'(outs_i[18:17]));
            compare("clock_ready_o", 32'(exp_outs_i[16]), 32'(outs_i[16]));
            compare("clk_en_o", 32'(exp_outs_i[15:14]), 32'(outs_i[15:14]));
            compare("clk_sel_o", 32'(exp_outs_i[13:12]), 32'(outs_i[13:12]));
            compare("phy_reset_n_o", 32'(exp_outs_i[11]), 32'(outs_i[11]));
            compare("div_sw_o", 32'(exp_outs_i[10:9]), 32'(outs_i[10:9]));
            compare("leds_o", 32'(exp_outs_i[8:1]), 32'(outs_i[8:1]));
            compare("int_o", 32'(exp_outs_i[0]), 32'(outs_i[0]));
         end
         if (test_end_i) begin
            tests++;
            $display("test %0d finished with %0d errors", test_id_i, errors - errs_before);
            errs_before = errors;
         end
         if (report_i)
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      end
   end

endmodule

// ==== tb/tb_u2plus_core.sv ====
////////////////////////////////////////////////////////////
// Testbench for the control bus core. Drives Wishbone reads
// and writes on the falling edge, keeps a model of the
// registers and hands expected values to the checker.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_u2plus_core import core_pkg::*; ();

   localparam int N_RAND      = 8;
   localparam int N_IRQ       = 3;
   localparam int A           = 3;   // Cycle budget per access
   localparam int TEST_CYCLES = 4 + A * (9 + N_RAND * (7 + 4 + 5) + N_IRQ * 14 + 26);
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic        wb_clk = 1'b0;
   logic        por_rst;
   logic [15:0] wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;
   logic        wb_we, wb_stb, wb_cyc, wb_ack;
   logic [3:0]  run;
   logic [11:0] adc0_a, adc0_b, adc1_a, adc1_b;
   logic [1:0]  aux_ld;
   logic        button, clk_status;
   logic [15:0] irq;
   logic [1:0]  clk_en, clk_sel, lms_res, div_sw;
   logic        clock_ready, phy_reset_n, int_o;
   logic [7:0]  leds;
   logic [18:0] obs, exp_outs;
   logic [31:0] exp_rd;
   logic        outs_chk = 1'b0;
   logic        test_end = 1'b0;
   logic        report = 1'b0;
   logic        ack_stall = 1'b0;
   logic [3:0]  test_id = '0;
   int          err_count;
   int          cycles = 0;
   int          seed;

   // Register model
   logic [6:0]  m_clock;
   logic [7:0]  m_led_sw, m_led_src;
   logic        m_phy;
   logic [1:0]  m_div_sw;
   logic [15:0] m_mask, m_pending;

   always #20 wb_clk = ~wb_clk;

   u2plus_core i_u2plus_core (
      .wb_clk, .por_rst,
      .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_we_i (wb_we),
      .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
      .run_i (run), .clk_en_o (clk_en), .clk_sel_o (clk_sel), .clock_ready_o (clock_ready),
      .lms_res_o (lms_res), .phy_reset_n_o (phy_reset_n), .div_sw_o (div_sw), .leds_o (leds),
      .adc0_a_i (adc0_a), .adc0_b_i (adc0_b), .adc1_a_i (adc1_a), .adc1_b_i (adc1_b),
      .aux_ld_i (aux_ld), .button_i (button), .clk_status_i (clk_status),
      .irq_i (irq), .int_o
   );

   assign obs = {lms_res, clock_ready, clk_en, clk_sel, phy_reset_n, div_sw, leds, int_o};

   core_checker i_core_checker (
      .wb_clk, .por_rst,
      .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc), .wb_we_i (wb_we), .wb_ack_i (wb_ack),
      .wb_dat_i (wb_dat_r), .exp_rd_i (exp_rd),
      .outs_chk_i (outs_chk), .outs_i (obs), .exp_outs_i (exp_outs),
      .test_end_i (test_end), .test_id_i (test_id), .report_i (report),
      .err_count_o (err_count)
   );

   ////////////////////////////////////////////////////////////
   // Reference functions
   function automatic logic [7:0] leds_ref(input logic [7:0] sw, input logic [7:0] src,
                                           input logic [3:0] run_v);
      logic [7:0] hw;
      logic [7:0] res;
      hw = {3'b000, run_v[3], run_v[2], run_v[1], run_v[0], 1'b0};
      for (int i = 0; i < 8; i++)
         res[i] = src[i] ? hw[i] : sw[i];   // Source 1 picks hardware
      return res;
   endfunction

   function automatic logic [31:0] adc_ref(input logic [11:0] a, input logic [11:0] b);
      return {a, 4'h0, b, 4'h0};
   endfunction

   function automatic logic [31:0] misc_ref(input logic [1:0] aux, input logic btn,
                                            input logic cks);
      logic [31:0] w;
      w     = '0;
      w[15] = aux[1];
      w[14] = aux[0];
      w[13] = btn;
      w[11] = cks;
      return w;
   endfunction

   function automatic logic [18:0] outs_ref();
      return {m_clock[6:5], m_clock[4], m_clock[3:2], m_clock[1:0], ~m_phy, m_div_sw,
              leds_ref(m_led_sw, m_led_src, run), |(m_pending & ~m_mask)};
   endfunction

   function automatic logic [15:0] rb_addr(input logic [3:0] idx);
      return {8'h5C, 2'b00, idx, 2'b00};
   endfunction

   function automatic logic [15:0] pic_addr(input logic [2:0] idx);
      return {8'h80, 3'b000, idx, 2'b00};
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus and check tasks
   task automatic bus_access(input logic [15:0] a, input logic write, input logic [31:0] d,
                             input logic [31:0] exp);
      int waits;
      @(negedge wb_clk);
      wb_adr   = a;
      wb_dat_w = d;
      wb_we    = write;
      exp_rd   = exp;
      wb_stb   = 1'b1;
      wb_cyc   = 1'b1;
      waits    = 0;
      do begin
         @(negedge wb_clk);
         waits++;
         if (waits > 8)
            ack_stall = 1'b1;   // Watchdog ends the run
      end while (!wb_ack);
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic set_write(input set_addr_t sa, input logic [31:0] d);
      bus_access({6'b01_1100, sa, 2'b00}, 1'b1, d, 32'h0);
   endtask

   task automatic check_outputs();
      exp_outs = outs_ref();
      outs_chk = 1'b1;
      @(negedge wb_clk);
      outs_chk = 1'b0;
   endtask

   task automatic end_test(input logic [3:0] id);
      @(negedge wb_clk);
      test_id  = id;
      test_end = 1'b1;
      @(negedge wb_clk);
      test_end = 1'b0;
   endtask

   task automatic model_reset();
      m_clock   = '0;
      m_led_sw  = '0;
      m_led_src = LED_SRC_RESET;
      m_phy     = 1'b0;
      m_div_sw  = {DIVSW_RESET, DIVSW_RESET};
      m_mask    = '1;
      m_pending = '0;
   endtask

   task automatic load_settings(input logic [31:0] rnd);
      m_clock   = rnd[6:0];
      m_led_sw  = rnd[15:8];
      m_led_src = rnd[23:16];
      m_phy     = rnd[24];
      m_div_sw  = rnd[26:25];
      set_write(SR_MISC, rnd);
      set_write(SR_MISC + 8'd3, rnd >> 8);
      set_write(SR_MISC + 8'd6, rnd >> 16);
      set_write(SR_MISC + 8'd4, rnd >> 24);
      set_write(SR_DIVSW, rnd >> 25);
      set_write(SR_DIVSW + 8'd1, rnd >> 26);
   endtask

   ////////////////////////////////////////////////////////////
   // Watchdog
   always @(posedge wb_clk) cycles <= cycles + 1;

   initial begin
      wait (cycles >= CYCLE_LIMIT || ack_stall);
      if (ack_stall)
         $display("bus access was never acknowledged");
      else
         $display("run stopped at the cycle limit");
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   initial begin
      logic [31:0] rnd;
      logic [15:0] irq_bit;
      int          n;
      seed     = 32'hb1bd;
      por_rst  = 1'b1;
      wb_adr   = '0;
      wb_dat_w = '0;
      exp_rd   = '0;
      exp_outs = '0;
      {wb_we, wb_stb, wb_cyc} = 3'b000;
      run      = '0;
      {adc0_a, adc0_b, adc1_a, adc1_b} = '0;
      {aux_ld, button, clk_status} = '0;
      irq      = '0;
      model_reset();
      repeat (4) @(negedge wb_clk);
      por_rst = 1'b0;

      // 1: reset values and unmapped accesses
      check_outputs();
      bus_access(pic_addr(PIC_MASK), 1'b0, 32'h0, 32'h0000_ffff);
      bus_access(16'h0000, 1'b0, 32'h0, 32'h0);
      bus_access(16'hF000, 1'b0, 32'h0, 32'h0);
      bus_access(16'h8400, 1'b0, 32'h0, 32'h0);   // Just above the PIC region
      bus_access(16'h6000, 1'b1, 32'hffff_ffff, 32'h0);
      bus_access(16'h6000, 1'b0, 32'h0, 32'h0);
      bus_access({6'b01_1100, SR_MISC, 2'b00}, 1'b0, 32'h0, 32'h0);
      check_outputs();
      end_test(4'd1);

      // 2: clock, PHY and diversity settings
      for (int i = 0; i < N_RAND; i++) begin
         rnd = $random(seed);
         load_settings(rnd);
         check_outputs();
      end
      end_test(4'd2);

      // 3: LED mixing
      for (int i = 0; i < N_RAND; i++) begin
         rnd = $random(seed);
         @(negedge wb_clk);
         run       = rnd[19:16];
         m_led_sw  = rnd[7:0];
         m_led_src = rnd[15:8];
         set_write(SR_MISC + 8'd3, rnd);
         set_write(SR_MISC + 8'd6, rnd >> 8);
         check_outputs();
      end
      end_test(4'd3);

      // 4: readback words
      for (int i = 0; i < N_RAND; i++) begin
         rnd = $random(seed);
         @(negedge wb_clk);
         {adc0_a, adc0_b} = {rnd[23:0]};
         rnd = $random(seed);
         {adc1_a, adc1_b} = {rnd[23:0]};
         {aux_ld, button, clk_status} = rnd[27:24];
         bus_access(rb_addr(RB_ADC0), 1'b0, 32'h0, adc_ref(adc0_a, adc0_b));
         bus_access(rb_addr(RB_ADC1), 1'b0, 32'h0, adc_ref(adc1_a, adc1_b));
         bus_access(rb_addr(RB_COMPAT), 1'b0, 32'h0, 32'h0008_0002);
         bus_access(rb_addr(RB_MISC), 1'b0, 32'h0, misc_ref(aux_ld, button, clk_status));
         bus_access(rb_addr(4'd0), 1'b0, 32'h0, 32'h0);
      end
      end_test(4'd4);

      // 5: interrupt controller
      for (int i = 0; i < N_IRQ; i++) begin
         rnd     = $random(seed);
         irq_bit = 16'h1 << rnd[3:0];
         @(negedge wb_clk);
         irq = irq_bit;
         repeat (2) @(negedge wb_clk);   // Edge reaches pending in 2 cycles
         m_pending = irq_bit;
         bus_access(pic_addr(PIC_PENDING), 1'b0, 32'h0, {16'h0, irq_bit});
         bus_access(pic_addr(PIC_RAW), 1'b0, 32'h0, {16'h0, irq_bit});
         check_outputs();
         m_mask = ~irq_bit;
         bus_access(pic_addr(PIC_MASK), 1'b1, {16'h0, ~irq_bit}, 32'h0);
         n = 0;
         while (!int_o && n < 2) begin
            @(negedge wb_clk);
            n++;
         end
         check_outputs();
         m_pending = '0;
         bus_access(pic_addr(PIC_PENDING), 1'b1, {16'h0, irq_bit}, 32'h0);
         check_outputs();
         bus_access(pic_addr(PIC_PENDING), 1'b0, 32'h0, 32'h0);
         @(negedge wb_clk);
         irq    = '0;
         m_mask = '1;
         bus_access(pic_addr(PIC_MASK), 1'b1, 32'h0000_ffff, 32'h0);
      end
      end_test(4'd5);

      // 6: boot-done reset, then a second write that must do nothing
      rnd = $random(seed);
      load_settings(rnd | 32'h0100_0000);   // PHY held in reset
      m_mask = '0;
      bus_access(pic_addr(PIC_MASK), 1'b1, 32'h0, 32'h0);   // All unmasked before core reset
      check_outputs();
      set_write(SR_MISC + 8'd5, 32'h1);
      n = 0;
      while (phy_reset_n !== 1'b1 && n < 4) begin
         @(negedge wb_clk);
         n++;
      end
      model_reset();
      check_outputs();
      bus_access(pic_addr(PIC_MASK), 1'b0, 32'h0, 32'h0000_ffff);
      rnd = $random(seed);
      load_settings(rnd);
      check_outputs();
      set_write(SR_MISC + 8'd5, 32'h1);
      repeat (4) @(negedge wb_clk);
      check_outputs();
      end_test(4'd6);

      @(negedge wb_clk);
      report = 1'b1;
      @(negedge wb_clk);
      report = 1'b0;
      @(negedge wb_clk);
      if (err_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== u2plus_core.f ====
source/core_pkg.sv
source/wb_slave_if.sv
source/bus_control.sv
source/settings_regs.sv
source/readback_mux.sv
source/pic.sv
source/u2plus_core.sv
tb/core_checker.sv
tb/tb_u2plus_core.sv
